// File: tb.f
rtl/kbdMatrixPkg.sv
rtl/kbdBusPkg.sv
rtl/ps2Receiver.sv
rtl/scanTranslator.sv
rtl/matrixArbiter.sv
rtl/keyMatrixRam.sv
rtl/matrixScanner.sv
rtl/bbcKeyboard.sv
verification/clockGen.sv
verification/bbcKeyboardTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = bbcKeyboardTb
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "no pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/bbcKeyboardTb.sv
`timescale 1ns/100ps

module bbcKeyboardTb import kbdMatrixPkg::*;;

	localparam int PS2_HALF      = 16;    // system clocks per ps2 clock phase
	localparam int KEY_LATENCY   = 40;    // frame end to visible key, upper bound
	localparam int SETTLE        = 6;     // host column change to stable match
	localparam int CLEAR_WAIT    = 100;   // post-reset matrix wipe
	localparam int STEP_LIMIT    = 20;
	localparam int TIMEOUT_LIMIT = 20000;

	logic                CLK_hPROC;
	logic                nRESET;
	logic                autoscan;
	logic [COL_BITS-1:0] column;
	logic [ROW_BITS-1:0] row;
	logic                ps2Clk;
	logic                ps2Data;
	logic                columnMatch;
	logic                rowMatch;
	logic [COL_BITS-1:0] scanColumn;

	keyCode_t            keyTable [0:127];
	bit                  keyMapped [0:127];
	logic [7:0]          keyState [0:15]; // expected key-down bits per column
	int                  errorCount;
	int                  checkCount;
	int                  cycleCount;
	int                  seed;

	clockGen clkGen (.CLK_hPROC(CLK_hPROC), .nRESET(nRESET));

	bbcKeyboard #(.SAMPLE_DIV(2)) dut_i (.*);

	task automatic waitCycles(input int n);
		repeat (n) @(posedge CLK_hPROC);
		#1; // drive and sample off the edge
	endtask

	task automatic reportMismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		errorCount++;
	endtask

	task automatic mapKey(input logic [6:0] scan, input logic [6:0] key);
		keyTable[scan]  = key;
		keyMapped[scan] = 1'b1;
	endtask

	task automatic loadKeyTable();
		for (int i = 0; i < 128; i++) begin
			keyMapped[i] = 1'b0;
		end
		for (int c = 0; c < 16; c++) begin
			keyState[c] = '0;
		end
		mapKey(7'h10, 7'h10); // q
		mapKey(7'h1E, 7'h41); // a
		mapKey(7'h2C, 7'h61); // z
		mapKey(7'h39, 7'h62); // space
		mapKey(7'h2A, 7'h00); // left shift
		mapKey(7'h11, 7'h21); // w
		mapKey(7'h3B, 7'h71); // f1
	endtask

	task automatic updateExpected(input logic [7:0] code);
		keyCode_t key;
		if (keyMapped[code[6:0]]) begin
			key = keyTable[code[6:0]];
			keyState[key.col][key.row] = !code[BREAK_BIT]; // break clears
		end
	endtask

	task automatic sendPs2(input logic [7:0] code, input bit badParity);
		logic [10:0] frameBits;
		logic        parity;
		parity = ~(^code); // odd parity
		if (badParity) begin
			parity = ~parity;
		end
		frameBits = {1'b1, parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2Data = frameBits[i];
			waitCycles(PS2_HALF);
			ps2Clk = 1'b0; // receiver samples on this edge
			waitCycles(PS2_HALF);
			ps2Clk = 1'b1;
		end
		ps2Data = 1'b1;
	endtask

	task automatic typeCode(input logic [7:0] code);
		sendPs2(code, 1'b0);
		updateExpected(code);
		waitCycles(KEY_LATENCY);
	endtask

	task automatic checkHostColumn(input int col);
		column = COL_BITS'(col);
		waitCycles(SETTLE);
		checkCount++;
		if (columnMatch !== (|keyState[col])) begin
			reportMismatch($sformatf("column %0d columnMatch %b", col, columnMatch));
		end
		for (int r = 0; r < ROW_COUNT; r++) begin
			row = ROW_BITS'(r);
			waitCycles(1); // rowMatch follows row directly
			checkCount++;
			if (rowMatch !== keyState[col][r]) begin
				reportMismatch($sformatf("column %0d row %0d rowMatch %b", col, r, rowMatch));
			end
		end
	endtask

	task automatic checkAllColumns();
		for (int c = 0; c < 16; c++) begin
			checkHostColumn(c);
		end
	endtask

	task automatic testResetClear();
		checkAllColumns();
	endtask

	task automatic testMakeKeys();
		typeCode(8'h10); // q, column 0 row 1
		checkAllColumns();
		typeCode(8'h39); // space, column 2 row 6
		checkAllColumns();
	endtask

	task automatic testBreakKeys();
		typeCode(8'h90);
		checkAllColumns();
		typeCode(8'hB9);
		checkAllColumns();
	endtask

	task automatic testSharedColumn();
		logic [7:0] first;
		logic [7:0] second;
		int         r;
		first  = 8'h1E;
		second = 8'h11;
		r = $random(seed);
		if (r[0]) begin
			first  = 8'h11;
			second = 8'h1E;
		end
		typeCode(first);
		typeCode(second);
		checkAllColumns();
		typeCode(first | 8'h80);
		checkAllColumns(); // the other key survives
		typeCode(second | 8'h80);
		checkAllColumns();
	endtask

	task automatic testIgnoredFrames();
		sendPs2(8'h2C, 1'b1); // would press z if accepted
		waitCycles(KEY_LATENCY);
		checkAllColumns();
		typeCode(8'h54); // no matrix key
		checkAllColumns();
	endtask

	task automatic waitScanStep(input logic [COL_BITS-1:0] prev, output bit stepped);
		int waited;
		waited = 0;
		while (scanColumn === prev && waited < STEP_LIMIT) begin
			waitCycles(1);
			waited++;
		end
		stepped = (scanColumn !== prev);
		if (!stepped) begin
			$display("ERROR at %0t ns: scanColumn stopped advancing in autoscan", $time);
			errorCount++;
		end
	endtask

	task automatic testAutoscan();
		logic [COL_BITS-1:0] prev;
		logic [COL_BITS-1:0] nextCol;
		bit                  stepped;
		typeCode(8'h2C); // z, column 1 row 6
		checkHostColumn(1);
		column = '0; // scanner also starts at column 0
		row    = keyTable[7'h2C].row; // held key's row, so host mode would match
		waitCycles(SETTLE);
		autoscan = 1'b1;
		for (int n = 0; n < 32; n++) begin
			prev = scanColumn;
			waitScanStep(prev, stepped);
			if (stepped) begin
				nextCol = prev + 1'b1;
				checkCount++;
				if (scanColumn !== nextCol) begin
					reportMismatch($sformatf("scanColumn %0d after %0d", scanColumn, prev));
				end
				checkCount++;
				if (columnMatch !== (|keyState[scanColumn])) begin
					reportMismatch($sformatf("autoscan column %0d columnMatch %b",
						scanColumn, columnMatch));
				end
				checkCount++;
				if (rowMatch !== 1'b0) begin
					reportMismatch("rowMatch high in autoscan");
				end
			end
		end
		autoscan = 1'b0;
	endtask

	initial begin : watchdog
		cycleCount = 0;
		while (cycleCount < TIMEOUT_LIMIT) begin
			@(posedge CLK_hPROC);
			cycleCount++;
		end
		$display("run stopped: no result after %0d cycles", TIMEOUT_LIMIT);
		$display("bbcKeyboardTb: %0d checks, %0d errors", checkCount, errorCount);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		seed       = 62529;
		errorCount = 0;
		checkCount = 0;
		autoscan   = 1'b0;
		column     = '0;
		row        = '0;
		ps2Clk     = 1'b1; // ps2 lines idle high
		ps2Data    = 1'b1;
		loadKeyTable();
		wait (nRESET === 1'b1);
		waitCycles(CLEAR_WAIT);
		testResetClear();
		testMakeKeys();
		testBreakKeys();
		testSharedColumn();
		testIgnoredFrames();
		testAutoscan();
		$display("bbcKeyboardTb: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: verification/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
	parameter int HALF_PERIOD  = 5, // ns, gives a 10 ns clock
	parameter int RESET_CYCLES = 8
) (
	output logic CLK_hPROC,
	output logic nRESET
);

	initial begin
		CLK_hPROC = 1'b0;
		forever #HALF_PERIOD CLK_hPROC = ~CLK_hPROC;
	end

	initial begin
		nRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_hPROC);
		#1 nRESET = 1'b1; // released just after the edge
	end

endmodule

// File: rtl/bbcKeyboard.sv
`timescale 1ns/100ps

module bbcKeyboard import kbdMatrixPkg::*, kbdBusPkg::*; #(
	parameter int SAMPLE_DIV = 6
) (
	input  logic                CLK_hPROC,
	input  logic                nRESET,
	input  logic                autoscan,
	input  logic [COL_BITS-1:0] column,
	input  logic [ROW_BITS-1:0] row,
	input  logic                ps2Clk,
	input  logic                ps2Data,
	output logic                columnMatch,
	output logic                rowMatch,
	output logic [COL_BITS-1:0] scanColumn
);

	logic                scanValid;
	logic [7:0]          scanCode;

	// translator master
	logic                tCyc, tStb, tWe, tAck;
	logic [WB_ADR_W-1:0] tAdr;
	logic [WB_DAT_W-1:0] tDatW, tDatR;

	// scanner master
	logic                sCyc, sStb, sWe, sAck;
	logic [WB_ADR_W-1:0] sAdr;
	logic [WB_DAT_W-1:0] sDatW, sDatR;

	// shared slave side
	logic                mCyc, mStb, mWe, mAck;
	logic [WB_ADR_W-1:0] mAdr;
	logic [WB_DAT_W-1:0] mDatW, mDatR;

	ps2Receiver #(.SAMPLE_DIV(SAMPLE_DIV)) receiver (.*);

	scanTranslator translator (.*);

	matrixArbiter arbiter (.*);

	keyMatrixRam matrixRam (.*);

	matrixScanner scanner (.*);

endmodule

// File: rtl/matrixScanner.sv
`timescale 1ns/100ps

module matrixScanner import kbdMatrixPkg::*, kbdBusPkg::*; (
	input  logic                CLK_hPROC,
	input  logic                nRESET,
	input  logic                autoscan,
	input  logic [COL_BITS-1:0] column,
	input  logic [ROW_BITS-1:0] row,
	input  logic [WB_DAT_W-1:0] sDatR,
	input  logic                sAck,
	output logic                sCyc,
	output logic                sStb,
	output logic                sWe,
	output logic [WB_ADR_W-1:0] sAdr,
	output logic [WB_DAT_W-1:0] sDatW,
	output logic                columnMatch,
	output logic                rowMatch,
	output logic [COL_BITS-1:0] scanColumn
);

	logic [COL_BITS-1:0]  autoColumn; // next column in autoscan
	logic [ROW_COUNT-1:0] colWord; // last word read

	assign sStb  = sCyc;
	assign sWe   = 1'b0; // read only master
	assign sDatW = '0;

	// host column goes straight to the bus, as the host drives it
	assign sAdr = autoscan ? autoColumn : column;

	assign rowMatch = !autoscan && colWord[row];

	always_ff @(posedge CLK_hPROC) begin
		if (!nRESET) begin
			sCyc        <= 1'b0;
			autoColumn  <= '0;
			scanColumn  <= '0;
			colWord     <= '0;
			columnMatch <= 1'b0;
		end else if (!sCyc) begin
			sCyc <= 1'b1; // one idle cycle frees the bus
		end else if (sAck) begin
			sCyc        <= 1'b0;
			colWord     <= sDatR;
			columnMatch <= |sDatR;
			scanColumn  <= sAdr;
			if (autoscan) begin
				autoColumn <= autoColumn + 1'b1;
			end
		end
	end

endmodule

// File: rtl/keyMatrixRam.sv
`timescale 1ns/100ps

module keyMatrixRam import kbdBusPkg::*; (
	input  logic                CLK_hPROC,
	input  logic                nRESET,
	input  logic                mCyc,
	input  logic                mStb,
	input  logic                mWe,
	input  logic [WB_ADR_W-1:0] mAdr,
	input  logic [WB_DAT_W-1:0] mDatW,
	output logic [WB_DAT_W-1:0] mDatR,
	output logic                mAck
);

	logic [WB_DAT_W-1:0] keyWords [0:(1 << WB_ADR_W) - 1];
	logic                access;

	// no new access while the previous ack is out
	assign access = mCyc && mStb && !mAck;

	always_ff @(posedge CLK_hPROC) begin
		if (!nRESET) begin
			mAck <= 1'b0;
		end else begin
			mAck <= access;
		end
	end

	always_ff @(posedge CLK_hPROC) begin
		if (access) begin
			if (mWe) begin
				keyWords[mAdr] <= mDatW;
			end
			mDatR <= keyWords[mAdr]; // old word, lands with ack
		end
	end

endmodule

// File: rtl/matrixArbiter.sv
`timescale 1ns/100ps

module matrixArbiter import kbdBusPkg::*; (
	input  logic                CLK_hPROC,
	input  logic                nRESET,
	input  logic                tCyc,
	input  logic                tStb,
	input  logic                tWe,
	input  logic [WB_ADR_W-1:0] tAdr,
	input  logic [WB_DAT_W-1:0] tDatW,
	input  logic                sCyc,
	input  logic                sStb,
	input  logic                sWe,
	input  logic [WB_ADR_W-1:0] sAdr,
	input  logic [WB_DAT_W-1:0] sDatW,
	output logic [WB_DAT_W-1:0] tDatR,
	output logic                tAck,
	output logic [WB_DAT_W-1:0] sDatR,
	output logic                sAck,
	output logic                mCyc,
	output logic                mStb,
	output logic                mWe,
	output logic [WB_ADR_W-1:0] mAdr,
	output logic [WB_DAT_W-1:0] mDatW,
	input  logic [WB_DAT_W-1:0] mDatR,
	input  logic                mAck
);

	logic grantT; // translator owns the slave
	logic grantS; // scanner owns the slave
	logic busLocked;

	assign busLocked = (grantT && tCyc) || (grantS && sCyc);

	always_ff @(posedge CLK_hPROC) begin
		if (!nRESET) begin
			grantT <= 1'b0;
			grantS <= 1'b0;
		end else if (!busLocked) begin
			grantT <= tCyc; // translator first
			grantS <= sCyc && !tCyc;
		end
	end

	assign mCyc  = (grantT && tCyc) || (grantS && sCyc);
	assign mStb  = (grantT && tStb) || (grantS && sStb);
	assign mWe   = grantT ? tWe : sWe;
	assign mAdr  = grantT ? tAdr : sAdr;
	assign mDatW = grantT ? tDatW : sDatW;

	assign tDatR = mDatR; // data fans out, ack says whose it is
	assign sDatR = mDatR;
	assign tAck  = grantT && mAck;
	assign sAck  = grantS && mAck;

endmodule

// File: rtl/scanTranslator.sv
`timescale 1ns/100ps

module scanTranslator import kbdMatrixPkg::*, kbdBusPkg::*; (
	input  logic                CLK_hPROC,
	input  logic                nRESET,
	input  logic                scanValid,
	input  logic [7:0]          scanCode,
	input  logic [WB_DAT_W-1:0] tDatR,
	input  logic                tAck,
	output logic                tCyc,
	output logic                tStb,
	output logic                tWe,
	output logic [WB_ADR_W-1:0] tAdr,
	output logic [WB_DAT_W-1:0] tDatW
);

	typedef enum logic [1:0] {stClear, stIdle, stRead, stWrite} state_t;

	state_t              state;
	keyCode_t            lookupKey;
	logic                lookupHit;
	keyCode_t            pendKey; // one-deep holding slot
	logic                pendBreak;
	logic                pendValid;
	logic [ROW_BITS-1:0] rowSel; // row of the key in flight
	logic                keyBreak;
	logic [WB_DAT_W-1:0] rowMask;

	assign tStb    = tCyc; // every open cycle carries a transfer
	assign rowMask = WB_DAT_W'(1) << rowSel;

	always_comb begin
		lookupHit = 1'b1;
		lookupKey = '0;
		case (scanCode[6:0])
			7'h10:   lookupKey = 7'h10; // q
			7'h11:   lookupKey = 7'h21; // w
			7'h1E:   lookupKey = 7'h41; // a
			7'h2A:   lookupKey = 7'h00; // left shift
			7'h36:   lookupKey = 7'h00; // right shift, same key
			7'h2C:   lookupKey = 7'h61; // z
			7'h39:   lookupKey = 7'h62; // space
			7'h3B:   lookupKey = 7'h71; // f1
			default: lookupHit = 1'b0;
		endcase
	end

	always_ff @(posedge CLK_hPROC) begin
		if (!nRESET) begin
			state     <= stClear;
			tCyc      <= 1'b0;
			tWe       <= 1'b0;
			tAdr      <= '0; // wipe walks up from column 0
			tDatW     <= '0;
			pendValid <= 1'b0;
		end else begin
			case (state)
				stClear: begin
					tCyc <= 1'b1;
					tWe  <= 1'b1;
					if (tAck) begin
						tAdr <= tAdr + 1'b1;
						if (&tAdr) begin // last column written
							tCyc  <= 1'b0;
							tWe   <= 1'b0;
							state <= stIdle;
						end
					end
				end
				stIdle: begin
					if (pendValid) begin
						tCyc      <= 1'b1;
						tAdr      <= pendKey.col;
						rowSel    <= pendKey.row;
						keyBreak  <= pendBreak;
						pendValid <= 1'b0;
						state     <= stRead;
					end
				end
				stRead: begin
					if (tAck) begin // cyc stays up, write follows at once
						tWe   <= 1'b1;
						tDatW <= keyBreak ? (tDatR & ~rowMask) : (tDatR | rowMask);
						state <= stWrite;
					end
				end
				default: begin
					if (tAck) begin
						tCyc  <= 1'b0;
						tWe   <= 1'b0;
						state <= stIdle;
					end
				end
			endcase
			if (scanValid && lookupHit) begin // newer code wins the slot
				pendValid <= 1'b1;
				pendKey   <= lookupKey;
				pendBreak <= scanCode[BREAK_BIT];
			end
		end
	end

endmodule

// File: rtl/ps2Receiver.sv
`timescale 1ns/100ps

module ps2Receiver #(
	parameter int SAMPLE_DIV = 6 // sample every 2**SAMPLE_DIV clocks
) (
	input  logic       CLK_hPROC,
	input  logic       nRESET,
	input  logic       ps2Clk,
	input  logic       ps2Data,
	output logic       scanValid,
	output logic [7:0] scanCode
);

	localparam int FRAME_BITS = 11; // start, 8 data, parity, stop

	logic [SAMPLE_DIV-1:0] divCount;
	logic [1:0]            clkSync; // two-flop synchronizer
	logic [1:0]            dataSync;
	logic                  clkLast; // ps2 clock at previous sample
	logic [3:0]            bitCount;
	logic [FRAME_BITS-1:0] frame;
	logic [FRAME_BITS-1:0] nextFrame;
	logic                  sampleEn;
	logic                  clkFall;
	logic                  lastBit;
	logic                  frameGood;

	assign sampleEn  = (divCount == '0);
	assign clkFall   = sampleEn && clkLast && !clkSync[1];
	assign lastBit   = (bitCount == 4'(FRAME_BITS - 1));
	assign nextFrame = {dataSync[1], frame[FRAME_BITS-1:1]}; // lsb arrives first

	// start low, stop high, odd parity over data plus parity bit
	assign frameGood = !nextFrame[0] && nextFrame[FRAME_BITS-1] && (^nextFrame[9:1]);

	always_ff @(posedge CLK_hPROC) begin
		if (!nRESET) begin
			divCount  <= '0;
			clkSync   <= 2'b11; // lines idle high
			dataSync  <= 2'b11;
			clkLast   <= 1'b1;
			bitCount  <= '0;
			scanValid <= 1'b0;
		end else begin
			divCount  <= divCount + 1'b1;
			clkSync   <= {clkSync[0], ps2Clk};
			dataSync  <= {dataSync[0], ps2Data};
			scanValid <= 1'b0;
			if (sampleEn) begin
				clkLast <= clkSync[1];
			end
			if (clkFall) begin
				if (lastBit) begin
					bitCount  <= '0;
					scanValid <= frameGood; // bad frames just vanish
				end else begin
					bitCount <= bitCount + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK_hPROC) begin
		if (clkFall) begin
			frame <= nextFrame;
		end
		if (clkFall && lastBit) begin
			scanCode <= nextFrame[8:1];
		end
	end

endmodule

// File: rtl/kbdBusPkg.sv
package kbdBusPkg;

	localparam int WB_ADR_W = 4; // one word per matrix column
	localparam int WB_DAT_W = 8; // one bit per matrix row

endpackage

// File: rtl/kbdMatrixPkg.sv
package kbdMatrixPkg;

	localparam int COL_BITS  = 4; // only columns 0 to 9 carry keys
	localparam int ROW_BITS  = 3;
	localparam int ROW_COUNT = 8; // bits in one column word
	localparam int BREAK_BIT = 7; // set-1 release flag

	// matrix position of one key, row in the upper bits
	typedef struct packed {
		logic [ROW_BITS-1:0] row;
		logic [COL_BITS-1:0] col;
	} keyCode_t;

endpackage
